// File: src/opn_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN bus definitions
// Port widths, timer register indices and
// bit positions of control and status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package opn_bus_pkg;

    typedef logic [7:0] bus_data_t;    // Processor data byte
    typedef logic [1:0] bus_addr_t;    // Bit 0 index/data, bit 1 bank
    typedef logic [7:0] reg_index_t;

    // Timer registers in bank 0
    localparam reg_index_t REG_TIMER_A_HI = 8'h24;  // Value A bits 9..2
    localparam reg_index_t REG_TIMER_A_LO = 8'h25;  // Value A bits 1..0
    localparam reg_index_t REG_TIMER_B    = 8'h26;
    localparam reg_index_t REG_TIMER_CTL  = 8'h27;

    // Control register fields
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_IRQ_A  = 2;
    localparam int CTL_IRQ_B  = 3;
    localparam int CTL_CLR_A  = 4;     // Write 1 to drop flag A
    localparam int CTL_CLR_B  = 5;

    // Status byte as seen on a read
    localparam int STAT_FLAG_A = 0;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_BUSY   = 7;

endpackage

// File: src/opn_timer_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN timer definitions
// Timer value types, held configuration
// and one-cycle command strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package opn_timer_pkg;

    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    // Held timer settings, written through the register port
    typedef struct packed {
        timer_a_t value_a;   // Reload value A
        timer_b_t value_b;   // Reload value B
        logic     run_a;
        logic     run_b;
        logic     irq_en_a;
        logic     irq_en_b;
    } timer_cfg_t;

    // Strobes, high for a single clock
    typedef struct packed {
        logic clr_a;
        logic clr_b;
    } timer_cmd_t;

    // Timer B advances once per this many time base ticks
    localparam int TIMER_B_SUBDIV = 16;

endpackage

// File: src/opn_reg_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN register port
// Index latch, timer register decode and
// the busy counter after data writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opn_reg_port #(
    parameter int BUSY_CYCLES = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cs_n,
    input  logic                     wr_n,
    input  opn_bus_pkg::bus_addr_t   addr,
    input  opn_bus_pkg::bus_data_t   din,
    output opn_timer_pkg::timer_cfg_t cfg,
    output opn_timer_pkg::timer_cmd_t cmd,
    output logic                     busy
);
    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

    opn_bus_pkg::reg_index_t index;
    logic [BUSY_W-1:0]       busy_cnt;
    logic                    write;
    logic                    index_wr;
    logic                    data_wr;

    assign write    = ~cs_n & ~wr_n;
    assign index_wr = write & ~addr[1] & ~addr[0];   // Bank 1 is not decoded
    assign data_wr  = write & ~addr[1] & addr[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
            cfg   <= '0;
            cmd   <= '0;
        end else begin
            cmd <= '0;                     // Strobes last one clock
            if (index_wr) begin
                index <= din;
            end
            if (data_wr) begin
                case (index)
                    opn_bus_pkg::REG_TIMER_A_HI: cfg.value_a[9:2] <= din;
                    opn_bus_pkg::REG_TIMER_A_LO: cfg.value_a[1:0] <= din[1:0];
                    opn_bus_pkg::REG_TIMER_B:    cfg.value_b      <= din;
                    opn_bus_pkg::REG_TIMER_CTL: begin
                        cfg.run_a    <= din[opn_bus_pkg::CTL_LOAD_A];
                        cfg.run_b    <= din[opn_bus_pkg::CTL_LOAD_B];
                        cfg.irq_en_a <= din[opn_bus_pkg::CTL_IRQ_A];
                        cfg.irq_en_b <= din[opn_bus_pkg::CTL_IRQ_B];
                        cmd.clr_a    <= din[opn_bus_pkg::CTL_CLR_A];
                        cmd.clr_b    <= din[opn_bus_pkg::CTL_CLR_B];
                    end
                    default: ;                 // Other indices belong to FM
                endcase
            end
        end
    end

    // Busy window restarts on every data write
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

endmodule

// File: src/opn_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN timer
// Reloading up-counter on the time base
// with an optional sub-divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opn_timer #(
    parameter int WIDTH  = 10,
    parameter int SUBDIV = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cen,
    input  logic             run,
    input  logic [WIDTH-1:0] value,
    output logic             overflow
);
    logic [WIDTH-1:0] cnt;
    logic             run_q;
    logic             load;    // First clock with run high
    logic             tick;    // Counter step

    assign load = run & ~run_q;

    generate
        if (SUBDIV > 1) begin : gen_subdiv
            localparam int DIV_W = $clog2(SUBDIV);
            logic [DIV_W-1:0] div;

            assign tick = cen & (div == DIV_W'(SUBDIV - 1));

            // Phase restarts with each start of the timer
            always_ff @(posedge clk) begin
                if (reset || load) begin
                    div <= '0;
                end else if (run && cen) begin
                    div <= tick ? '0 : div + 1'b1;
                end
            end
        end else begin : gen_nodiv
            assign tick = cen;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q    <= 1'b0;
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            run_q    <= run;
            overflow <= 1'b0;
            if (load) begin
                cnt <= value;
            end else if (run && tick) begin
                if (&cnt) begin
                    cnt      <= value;     // Wrap back to the reload value
                    overflow <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/opn_status.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN status
// Timer flags, IRQ line and status byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opn_status (
    input  logic                      clk,
    input  logic                      reset,
    input  opn_timer_pkg::timer_cfg_t cfg,
    input  opn_timer_pkg::timer_cmd_t cmd,
    input  logic                      busy,
    input  logic                      overflow_a,
    input  logic                      overflow_b,
    output opn_bus_pkg::bus_data_t    dout,
    output logic                      irq_n
);
    logic flag_a;
    logic flag_b;

    // Clear has priority over a coincident overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (cmd.clr_a) begin
                flag_a <= 1'b0;
            end else if (overflow_a && cfg.irq_en_a) begin
                flag_a <= 1'b1;
            end
            if (cmd.clr_b) begin
                flag_b <= 1'b0;
            end else if (overflow_b && cfg.irq_en_b) begin
                flag_b <= 1'b1;
            end
        end
    end

    // Active low, behaves like an open-drain pull down
    assign irq_n = ~((flag_a & cfg.irq_en_a) | (flag_b & cfg.irq_en_b));

    always_comb begin
        dout                          = '0;
        dout[opn_bus_pkg::STAT_FLAG_A] = flag_a;
        dout[opn_bus_pkg::STAT_FLAG_B] = flag_b;
        dout[opn_bus_pkg::STAT_BUSY]   = busy;
    end

endmodule

// File: src/opn_timer_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN timer slice top level
// Register port, timers A and B and the
// status block behind the processor bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opn_timer_top #(
    parameter int BUSY_CYCLES = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cen,      // Time base enable
    input  logic                   cs_n,
    input  logic                   wr_n,
    input  opn_bus_pkg::bus_addr_t addr,
    input  opn_bus_pkg::bus_data_t din,
    output opn_bus_pkg::bus_data_t dout,
    output logic                   irq_n
);
    opn_timer_pkg::timer_cfg_t cfg;
    opn_timer_pkg::timer_cmd_t cmd;
    logic                      busy;
    logic                      overflow_a;
    logic                      overflow_b;

    opn_reg_port #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_port (
        .clk   (clk),
        .reset (reset),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .addr  (addr),
        .din   (din),
        .cfg   (cfg),
        .cmd   (cmd),
        .busy  (busy)
    );

    // Timer A steps on every time base tick
    opn_timer #(
        .WIDTH  ($bits(opn_timer_pkg::timer_a_t)),
        .SUBDIV (1)
    ) u_timer_a (
        .clk      (clk),
        .reset    (reset),
        .cen      (cen),
        .run      (cfg.run_a),
        .value    (cfg.value_a),
        .overflow (overflow_a)
    );

    opn_timer #(
        .WIDTH  ($bits(opn_timer_pkg::timer_b_t)),
        .SUBDIV (opn_timer_pkg::TIMER_B_SUBDIV)
    ) u_timer_b (
        .clk      (clk),
        .reset    (reset),
        .cen      (cen),
        .run      (cfg.run_b),
        .value    (cfg.value_b),
        .overflow (overflow_b)
    );

    opn_status u_status (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .cmd        (cmd),
        .busy       (busy),
        .overflow_a (overflow_a),
        .overflow_b (overflow_b),
        .dout       (dout),
        .irq_n      (irq_n)
    );

endmodule

// File: bench/opn_timer_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN status checks
// IRQ, flag enable and busy rules, bound
// into the status block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opn_timer_properties (
    input logic                      clk,
    input logic                      reset,
    input opn_timer_pkg::timer_cfg_t cfg,
    input opn_timer_pkg::timer_cmd_t cmd,
    input logic                      busy,
    input logic                      flag_a,
    input logic                      flag_b,
    input logic                      irq_n
);
    int unsigned failures = 0;   // Count of failed assertions

    // Line pulled low exactly while an enabled flag is up
    irq_follows_flags: assert property (
        @(posedge clk) disable iff (reset)
        (irq_n == 1'b0) == ((flag_a && cfg.irq_en_a) || (flag_b && cfg.irq_en_b))
    ) else begin
        failures++;
        $error("irq_n disagrees with the enabled flags");
    end

    flag_a_enabled: assert property (
        @(posedge clk) disable iff (reset) $rose(flag_a) |-> $past(cfg.irq_en_a)
    ) else begin
        failures++;
        $error("flag A rose with its IRQ enable low");
    end

    flag_b_enabled: assert property (
        @(posedge clk) disable iff (reset) $rose(flag_b) |-> $past(cfg.irq_en_b)
    ) else begin
        failures++;
        $error("flag B rose with its IRQ enable low");
    end

    // An accepted data write shows as a cfg change or a clear strobe
    busy_after_write: assert property (
        @(posedge clk) disable iff (reset)
        (!$stable(cfg) || cmd.clr_a || cmd.clr_b) |-> busy
    ) else begin
        failures++;
        $error("busy low after an accepted data write");
    end

endmodule

bind opn_status opn_timer_properties u_properties (
    .clk    (clk),
    .reset  (reset),
    .cfg    (cfg),
    .cmd    (cmd),
    .busy   (busy),
    .flag_a (flag_a),
    .flag_b (flag_b),
    .irq_n  (irq_n)
);

// File: bench/opn_timer_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPN timer slice testbench
// Random bus traffic and time base against
// a cycle model of timers, flags and busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opn_timer_tb;
    localparam int BUSY_CYCLES = 32;

    logic                   clk;
    logic                   reset;
    logic                   cen;
    logic                   cs_n;
    logic                   wr_n;
    opn_bus_pkg::bus_addr_t addr;
    opn_bus_pkg::bus_data_t din;
    opn_bus_pkg::bus_data_t dout;
    logic                   irq_n;
    integer                 seed;

    // Model state updated once per rising edge
    opn_timer_pkg::timer_cfg_t m_cfg;
    opn_timer_pkg::timer_cmd_t m_cmd;
    opn_bus_pkg::reg_index_t   m_index;
    opn_timer_pkg::timer_a_t   m_cnt_a;
    opn_timer_pkg::timer_b_t   m_cnt_b;
    int                        m_div_b;
    int                        m_busy_cnt;
    logic                      m_run_q_a;
    logic                      m_run_q_b;
    logic                      m_ovf_a;
    logic                      m_ovf_b;
    logic                      m_flag_a;
    logic                      m_flag_b;

    opn_timer_top #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .cen   (cen),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .addr  (addr),
        .din   (din),
        .dout  (dout),
        .irq_n (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic opn_bus_pkg::bus_data_t rand_byte();
        return 8'(rand_below(256));
    endfunction

    function automatic opn_bus_pkg::bus_data_t ctl_byte(
        input logic run_a, input logic run_b, input logic en_a,
        input logic en_b, input logic clr_a, input logic clr_b
    );
        opn_bus_pkg::bus_data_t b;
        b = '0;
        b[opn_bus_pkg::CTL_LOAD_A] = run_a;
        b[opn_bus_pkg::CTL_LOAD_B] = run_b;
        b[opn_bus_pkg::CTL_IRQ_A]  = en_a;
        b[opn_bus_pkg::CTL_IRQ_B]  = en_b;
        b[opn_bus_pkg::CTL_CLR_A]  = clr_a;
        b[opn_bus_pkg::CTL_CLR_B]  = clr_b;
        return b;
    endfunction

    task automatic model_reset();
        m_cfg      = '0;
        m_cmd      = '0;
        m_index    = '0;
        m_cnt_a    = '0;
        m_cnt_b    = '0;
        m_div_b    = 0;
        m_busy_cnt = 0;
        m_run_q_a  = 1'b0;
        m_run_q_b  = 1'b0;
        m_ovf_a    = 1'b0;
        m_ovf_b    = 1'b0;
        m_flag_a   = 1'b0;
        m_flag_b   = 1'b0;
    endtask

    task automatic model_step();
        logic write;
        logic data_wr;
        logic load;
        // Flags see last cycle's overflow and clear with clear first
        if (m_cmd.clr_a) begin
            m_flag_a = 1'b0;
        end else if (m_ovf_a && m_cfg.irq_en_a) begin
            m_flag_a = 1'b1;
        end
        if (m_cmd.clr_b) begin
            m_flag_b = 1'b0;
        end else if (m_ovf_b && m_cfg.irq_en_b) begin
            m_flag_b = 1'b1;
        end
        load      = m_cfg.run_a && !m_run_q_a;   // Timer A steps on each cen
        m_run_q_a = m_cfg.run_a;
        m_ovf_a   = 1'b0;
        if (load) begin
            m_cnt_a = m_cfg.value_a;
        end else if (m_cfg.run_a && cen) begin
            m_ovf_a = (m_cnt_a == 10'h3ff);
            m_cnt_a = m_ovf_a ? m_cfg.value_a : m_cnt_a + 1'b1;
        end
        load      = m_cfg.run_b && !m_run_q_b;
        m_run_q_b = m_cfg.run_b;
        m_ovf_b   = 1'b0;
        if (load) begin
            m_div_b = 0;                          // Divider phase restarts
            m_cnt_b = m_cfg.value_b;
        end else if (m_cfg.run_b && cen) begin
            if (m_div_b == opn_timer_pkg::TIMER_B_SUBDIV - 1) begin
                m_div_b = 0;
                m_ovf_b = (m_cnt_b == 8'hff);
                m_cnt_b = m_ovf_b ? m_cfg.value_b : m_cnt_b + 1'b1;
            end else begin
                m_div_b = m_div_b + 1;
            end
        end
        write   = !cs_n && !wr_n && !addr[1];     // Bank 1 is ignored
        data_wr = write && addr[0];
        if (data_wr) begin
            m_busy_cnt = BUSY_CYCLES;
        end else if (m_busy_cnt > 0) begin
            m_busy_cnt = m_busy_cnt - 1;
        end
        m_cmd = '0;
        if (write && !addr[0]) begin
            m_index = din;
        end
        if (data_wr) begin
            case (m_index)
                opn_bus_pkg::REG_TIMER_A_HI: m_cfg.value_a[9:2] = din;
                opn_bus_pkg::REG_TIMER_A_LO: m_cfg.value_a[1:0] = din[1:0];
                opn_bus_pkg::REG_TIMER_B:    m_cfg.value_b      = din;
                opn_bus_pkg::REG_TIMER_CTL: begin
                    m_cfg.run_a    = din[opn_bus_pkg::CTL_LOAD_A];
                    m_cfg.run_b    = din[opn_bus_pkg::CTL_LOAD_B];
                    m_cfg.irq_en_a = din[opn_bus_pkg::CTL_IRQ_A];
                    m_cfg.irq_en_b = din[opn_bus_pkg::CTL_IRQ_B];
                    m_cmd.clr_a    = din[opn_bus_pkg::CTL_CLR_A];
                    m_cmd.clr_b    = din[opn_bus_pkg::CTL_CLR_B];
                end
                default: ;
            endcase
        end
    endtask

    function automatic opn_bus_pkg::bus_data_t expected_status();
        opn_bus_pkg::bus_data_t s;
        s = '0;
        s[opn_bus_pkg::STAT_FLAG_A] = m_flag_a;
        s[opn_bus_pkg::STAT_FLAG_B] = m_flag_b;
        s[opn_bus_pkg::STAT_BUSY]   = (m_busy_cnt != 0);
        return s;
    endfunction

    function automatic logic expected_irq();
        return !((m_flag_a && m_cfg.irq_en_a) || (m_flag_b && m_cfg.irq_en_b));
    endfunction

    task automatic check_status(input opn_bus_pkg::bus_data_t expected,
                                input opn_bus_pkg::bus_data_t actual);
        if (actual !== expected) begin
            $display("[ERROR] dout expected %h actual %h at %0t", expected, actual, $time);
            abort_run();
        end
    endtask

    task automatic check_irq(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] irq_n expected %h actual %h at %0t", expected, actual, $time);
            abort_run();
        end
    endtask

    // Drive at the falling edge and model at the rising edge
    task automatic bus_cycle(input logic cs_v, input logic wr_v,
                             input opn_bus_pkg::bus_addr_t a_v,
                             input opn_bus_pkg::bus_data_t d_v);
        cs_n = cs_v;
        wr_n = wr_v;
        addr = a_v;
        din  = d_v;
        cen  = (rand_below(3) == 0);   // Time base about one clock in three
        @(posedge clk);
        model_step();
        @(negedge clk);
        check_status(expected_status(), dout);
        check_irq(expected_irq(), irq_n);
        if (i_dut.u_status.u_properties.failures != 0) begin
            $display("An assertion on the status block failed at %0t", $time);
            abort_run();
        end
    endtask

    task automatic idle(input int n);
        repeat (n) bus_cycle(1'b1, 1'b1, 2'b00, 8'h00);
    endtask

    task automatic write_reg(input logic bank, input opn_bus_pkg::reg_index_t idx,
                             input opn_bus_pkg::bus_data_t data);
        bus_cycle(1'b0, 1'b0, {bank, 1'b0}, idx);
        bus_cycle(1'b0, 1'b0, {bank, 1'b1}, data);
    endtask

    task automatic wait_status_bit(input logic [2:0] bit_pos, input logic level,
                                   input int limit, input string what);
        int count;
        count = 0;
        while (dout[bit_pos] !== level) begin
            if (count == limit) begin
                $display("Timeout: %s did not happen within %0d cycles", what, limit);
                abort_run();
            end else begin
                idle(1);
                count++;
            end
        end
    endtask

    initial begin
        seed  = 5;
        reset = 1'b1;
        cen   = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        addr  = '0;
        din   = '0;
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_status(expected_status(), dout);
        check_irq(expected_irq(), irq_n);

        write_reg(1'b0, opn_bus_pkg::REG_TIMER_A_HI, rand_byte());
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_A_LO, rand_byte());
        wait_status_bit(3'(opn_bus_pkg::STAT_BUSY), 1'b0, BUSY_CYCLES + 2, "busy to drop");

        // Timer A near the top of its range keeps the period short
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_A_HI, 8'hf0 | 8'(rand_below(16)));
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 0, 0));
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_A), 1'b1, 3000, "flag A");
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 1, 0));
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_A), 1'b0, 4, "flag A clear");
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_A), 1'b1, 3000, "second flag A");

        write_reg(1'b0, opn_bus_pkg::REG_TIMER_B, 8'hf0 | 8'(rand_below(16)));
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 1, 0, 1, 1, 0));
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_B), 1'b1, 4000, "flag B");

        // Masked timers keep wrapping without raising flags
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 1, 0, 0, 0, 1));
        idle(1200);
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 1, 1, 1, 0, 0));
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_A), 1'b1, 3000, "flag A enabled");
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_B), 1'b1, 4000, "flag B enabled");
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 1, 1, 1, 1, 0));
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_A), 1'b0, 4, "flag A clear");
        write_reg(1'b0, opn_bus_pkg::REG_TIMER_CTL, ctl_byte(1, 1, 1, 1, 0, 1));
        wait_status_bit(3'(opn_bus_pkg::STAT_FLAG_B), 1'b0, 4, "flag B clear");

        repeat (1500) begin
            case (rand_below(4))
                0: write_reg(1'b0, 8'(8'h24 + rand_below(4)), rand_byte());
                1: write_reg(1'b1, 8'(8'h24 + rand_below(4)), rand_byte());   // Bank 1 has no effect
                2: bus_cycle(1'(rand_below(2)), 1'(rand_below(2)), 2'(rand_below(4)),
                             rand_byte());
                default: idle(rand_below(16));
            endcase
        end
        idle(20);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: opn_timer.f
src/opn_bus_pkg.sv
src/opn_timer_pkg.sv
src/opn_reg_port.sv
src/opn_timer.sv
src/opn_status.sv
src/opn_timer_top.sv
bench/opn_timer_properties.sv
bench/opn_timer_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the OPN timer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module opn_timer_tb -f opn_timer.f

output=$(./obj_dir/Vopn_timer_tb) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
